// ==== sim/id_cases.txt ====
# name valid stall flush rnd pc inst exc causes exp_valid kind iv aluop alusel rre rra1 rra0 rwe rwa imm cre cwe csr priv
# kind 0 decoded record, 1 all zero, 2 hold previous; rra and rwa are decimal, rnd 1 uses a random pc
llw 1 0 0 0 00001000 20800464 00 000000000 1 0 1 12 3 1 0 3 1 4 ffff8004 1 0 060 0
scw 1 0 0 0 00001004 210040a6 37 123456789 1 0 1 13 3 3 6 5 1 6 00000000 1 0 060 0
csrrd 1 0 0 1 00000000 04000407 00 000000000 1 0 1 20 4 0 0 0 1 7 00000000 1 0 001 1
csrwr 1 0 0 0 00001010 04001428 21 fc0000fff 1 0 1 21 4 1 0 8 1 8 00000000 1 1 005 1
csrxchg 1 0 0 0 00001014 0406012a 08 000fc0000 1 0 1 22 4 3 9 10 1 10 00000000 1 1 180 1
addiw 1 0 0 0 00002000 02bffc22 00 000000000 1 0 1 01 1 1 0 1 1 2 ffffffff 0 0 000 0
ldw 1 0 0 1 00000000 28804064 12 abcdef012 1 0 1 10 3 1 0 3 1 4 00000010 0 0 000 0
stw 1 0 0 0 00002008 29a000a6 00 000000000 1 0 1 11 3 3 6 5 0 0 fffff800 0 0 000 0
addw 1 0 0 0 0000200c 00100c41 3f 555555555 1 0 1 01 1 3 3 2 1 1 00000000 0 0 000 0
subw 1 0 0 0 00002010 001110a6 00 000000000 1 0 1 02 1 3 4 5 1 6 00000000 0 0 000 0
and 1 0 0 1 00000000 00149d09 25 0f0f0f0f0 1 0 1 03 2 3 7 8 1 9 00000000 0 0 000 0
or 1 0 0 0 00002018 0015296c 00 000000000 1 0 1 04 2 3 10 11 1 12 00000000 0 0 000 0
ine_ones 1 0 0 0 00003000 ffffffff 37 fedcba987 1 0 0 00 0 0 0 31 0 0 00000000 0 0 3fff 0
ine_zero 1 0 0 0 00003004 00000000 00 000000000 1 0 0 00 0 0 0 0 0 0 00000000 0 0 0000 0
bubble 0 0 0 0 00003008 00100c41 00 000000000 0 0 1 01 1 3 3 2 1 1 00000000 0 0 000 0
or_again 1 0 0 0 0000300c 0015296c 11 111111111 1 0 1 04 2 3 10 11 1 12 00000000 0 0 000 0
stall_hold 1 1 0 0 00003010 00100c41 3f 000000000 1 2 0 00 0 0 0 0 0 0 00000000 0 0 000 0
stall_hold2 0 1 0 1 00000000 28804064 00 abcabcabc 1 2 0 00 0 0 0 0 0 0 00000000 0 0 000 0
flush_stall 1 1 1 0 00003018 00100c41 00 000000000 0 1 0 00 0 0 0 0 0 0 00000000 0 0 000 0
after_flush 1 0 0 0 0000301c 00100c41 00 000000000 1 0 1 01 1 3 3 2 1 1 00000000 0 0 000 0
flush 1 0 1 0 00003020 0406012a 00 000000000 0 1 0 00 0 0 0 0 0 0 00000000 0 0 000 0
csrrd_last 1 0 0 0 00003024 04000407 37 000000000 1 0 1 20 4 0 0 0 1 7 00000000 1 0 001 1

// ==== id_stage.f ====
+incdir+common
common/pipeline_pkg.sv
design/decoder/decoder_2ri14.sv
design/decoder/decoder_2ri12.sv
design/decoder/decoder_3r.sv
design/id_stage.sv
sim/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f id_stage.f --top-module tb_id_stage -o sim_id_stage
./obj_dir/sim_id_stage 2>&1 | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim/tb_id_stage.sv ====
`include "core_macros.svh"

module tb_id_stage
    import pipeline_pkg::*;
();

    logic                              clk;
    logic                              rst_n_i;
    logic                              valid_i;
    bus32_t                            pc_i;
    bus32_t                            inst_i;
    logic [`EXC_SLOTS-1:0]             is_exception_i;
    exception_cause_t [`EXC_SLOTS-1:0] exception_cause_i;
    logic                              stall_i;
    logic                              flush_i;
    logic                              valid_o;
    id_dispatch_t                      id_o;

    integer seed;

    id_stage dut0 (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .valid_i           (valid_i),
        .pc_i              (pc_i),
        .inst_i            (inst_i),
        .is_exception_i    (is_exception_i),
        .exception_cause_i (exception_cause_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .valid_o           (valid_o),
        .id_o              (id_o)
    );

    always #5 clk = ~clk;

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s valid_o expected %0b actual %0b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_dispatch(input string name, input id_dispatch_t exp,
                                  input id_dispatch_t act);
        if (act !== exp) begin
            $display("Mismatch %s id_o expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    // steps one time unit at a time until the clock shows the wanted level.
    task automatic wait_clk_level(input logic level);
        int n;
        n = 0;
        while (clk !== level && n < 20) begin
            #1;
            n++;
        end
        if (clk !== level) begin
            $display("timeout: clock did not reach level %0b", level);
            stop_on_error();
        end
    endtask

    initial begin
        int           fd;
        int           code;
        int           ncases;
        string        name;
        string        line;
        logic         v_f, s_f, f_f, rnd_f, exp_valid, iv;
        logic [31:0]  pc_f, inst_f, pc_val, imm_f;
        logic [5:0]   exc_f;
        logic [35:0]  cause_f;
        logic [1:0]   kind;
        logic [7:0]   aluop_f;
        logic [2:0]   alusel_f;
        logic [1:0]   rre_f;
        logic [4:0]   rra1_f, rra0_f, rwa_f;
        logic         rwe_f, cre_f, cwe_f, priv_f;
        logic [13:0]  csr_f;
        id_dispatch_t exp;
        id_dispatch_t prev_id;

        clk               = 1'b0;
        rst_n_i           = 1'b0;
        valid_i           = 1'b0;
        stall_i           = 1'b0;
        flush_i           = 1'b0;
        pc_i              = '0;
        inst_i            = '0;
        is_exception_i    = '0;
        exception_cause_i = '0;
        seed              = 32'h78f4;
        ncases            = 0;

        fd = $fopen("sim/id_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file sim/id_cases.txt");
            stop_on_error();
        end

        repeat (5) begin
            wait_clk_level(1'b1);
            wait_clk_level(1'b0);
        end
        check_valid("reset", 1'b0, valid_o);
        check_dispatch("reset", '0, id_o);
        rst_n_i = 1'b1;
        prev_id = '0;

        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) break;
            if (name.substr(0, 0) == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            code = $fscanf(fd, " %d %d %d %d %h %h %h %h",
                           v_f, s_f, f_f, rnd_f, pc_f, inst_f, exc_f, cause_f);
            code += $fscanf(fd, " %d %d %d %h %h %h %d %d %d %d %h %d %d %h %d",
                            exp_valid, kind, iv, aluop_f, alusel_f, rre_f, rra1_f, rra0_f,
                            rwe_f, rwa_f, imm_f, cre_f, cwe_f, csr_f, priv_f);
            if (code != 23) begin
                $display("case line for %s could not be parsed", name);
                stop_on_error();
            end
            pc_val = rnd_f ? $random(seed) : pc_f;

            valid_i           = v_f;
            stall_i           = s_f;
            flush_i           = f_f;
            pc_i              = pc_val;
            inst_i            = inst_f;
            is_exception_i    = exc_f;
            exception_cause_i = cause_f;
            wait_clk_level(1'b1);
            wait_clk_level(1'b0);

            exp = '0;
            if (kind == 2'd0) begin
                exp.pc               = pc_val;
                exp.inst_valid       = iv;
                exp.aluop            = aluop_f;
                exp.alusel           = alusel_f;
                exp.reg_read_en      = rre_f;
                exp.reg_read_addr[1] = rra1_f;
                exp.reg_read_addr[0] = rra0_f;
                exp.reg_write_en     = rwe_f;
                exp.reg_write_addr   = rwa_f;
                exp.imm              = imm_f;
                exp.csr_read_en      = cre_f;
                exp.csr_write_en     = cwe_f;
                exp.csr_addr         = csr_f;
                exp.is_privilege     = priv_f;
                // decode owns slot 3 and the others pass through.
                exp.is_exception     = exc_f;
                exp.exception_cause  = cause_f;
                exp.is_exception[`EXC_SLOT_ID]    = ~iv;
                exp.exception_cause[`EXC_SLOT_ID] = `EXCEPTION_INE;
            end else if (kind == 2'd2) begin
                exp = prev_id;
            end
            check_valid(name, exp_valid, valid_o);
            check_dispatch(name, exp, id_o);
            prev_id = exp;
            ncases++;
        end
        $fclose(fd);

        if (ncases == 0) begin
            $display("no cases were read from the case file");
            stop_on_error();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== design/id_stage.sv ====
`include "core_macros.svh"

module id_stage
    import pipeline_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  bus32_t                            pc_i,
    input  bus32_t                            inst_i,
    input  logic [`EXC_SLOTS-1:0]             is_exception_i,
    input  exception_cause_t [`EXC_SLOTS-1:0] exception_cause_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    output logic                              valid_o,
    output id_dispatch_t                      id_o
);

    inst_word_t   inst_word;
    id_dispatch_t id_2ri14;
    id_dispatch_t id_2ri12;
    id_dispatch_t id_3r;
    id_dispatch_t id_sel;

    assign inst_word = inst_i;

    decoder_2ri14 u_decoder_2ri14 (
        .pc_i              (pc_i),
        .inst_i            (inst_word),
        .is_exception_i    (is_exception_i),
        .exception_cause_i (exception_cause_i),
        .id_o              (id_2ri14)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .pc_i              (pc_i),
        .inst_i            (inst_word),
        .is_exception_i    (is_exception_i),
        .exception_cause_i (exception_cause_i),
        .id_o              (id_2ri12)
    );

    decoder_3r u_decoder_3r (
        .pc_i              (pc_i),
        .inst_i            (inst_word),
        .is_exception_i    (is_exception_i),
        .exception_cause_i (exception_cause_i),
        .id_o              (id_3r)
    );

    // opcodes are disjoint and the 2ri14 record carries INE when nobody claims.
    always_comb begin
        if (id_2ri12.inst_valid) begin
            id_sel = id_2ri12;
        end else if (id_3r.inst_valid) begin
            id_sel = id_3r;
        end else begin
            id_sel = id_2ri14;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            id_o    <= '0;
        end else if (flush_i) begin
            // flush wins over stall and empties the whole slot.
            valid_o <= 1'b0;
            id_o    <= '0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
            id_o    <= id_sel;
        end
    end

endmodule

// ==== design/decoder/decoder_3r.sv ====
`include "core_macros.svh"

module decoder_3r
    import pipeline_pkg::*;
(
    input  bus32_t                            pc_i,
    input  inst_word_t                        inst_i,
    input  logic [`EXC_SLOTS-1:0]             is_exception_i,
    input  exception_cause_t [`EXC_SLOTS-1:0] exception_cause_i,
    output id_dispatch_t                      id_o
);

    logic inst_valid;

    always_comb begin
        id_o                  = '0;
        id_o.pc               = pc_i;
        id_o.aluop            = `ALU_NOP;
        id_o.alusel           = `ALU_SEL_NOP;
        id_o.reg_read_addr[0] = inst_i.r3.rj;
        id_o.reg_read_addr[1] = inst_i.r3.rk;
        id_o.is_exception     = is_exception_i;
        id_o.exception_cause  = exception_cause_i;
        inst_valid            = 1'b1;

        case (inst_i.r3.opcode)
            `ADDW_OPCODE: begin
                id_o.aluop  = `ALU_ADD;
                id_o.alusel = `ALU_SEL_ARITH;
            end
            `SUBW_OPCODE: begin
                id_o.aluop  = `ALU_SUB;
                id_o.alusel = `ALU_SEL_ARITH;
            end
            `AND_OPCODE: begin
                id_o.aluop  = `ALU_AND;
                id_o.alusel = `ALU_SEL_LOGIC;
            end
            `OR_OPCODE: begin
                id_o.aluop  = `ALU_OR;
                id_o.alusel = `ALU_SEL_LOGIC;
            end
            default: begin
                inst_valid = 1'b0;
            end
        endcase

        // two sources, one destination.
        id_o.reg_read_en    = {2{inst_valid}};
        id_o.reg_write_en   = inst_valid;
        id_o.reg_write_addr = inst_valid ? inst_i.r3.rd : 5'b0;

        id_o.inst_valid                    = inst_valid;
        id_o.is_exception[`EXC_SLOT_ID]    = ~inst_valid;
        id_o.exception_cause[`EXC_SLOT_ID] = `EXCEPTION_INE;
    end

endmodule

// ==== design/decoder/decoder_2ri12.sv ====
`include "core_macros.svh"

module decoder_2ri12
    import pipeline_pkg::*;
(
    input  bus32_t                            pc_i,
    input  inst_word_t                        inst_i,
    input  logic [`EXC_SLOTS-1:0]             is_exception_i,
    input  exception_cause_t [`EXC_SLOTS-1:0] exception_cause_i,
    output id_dispatch_t                      id_o
);

    logic [9:0]  opcode;
    logic [11:0] si12;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic        inst_valid;

    assign opcode = inst_i.ri12.opcode;
    assign si12   = inst_i.ri12.si12;
    assign rj     = inst_i.ri12.rj;
    assign rd     = inst_i.ri12.rd;

    always_comb begin
        id_o                  = '0;
        id_o.pc               = pc_i;
        id_o.aluop            = `ALU_NOP;
        id_o.alusel           = `ALU_SEL_NOP;
        id_o.reg_read_addr[0] = rj;
        id_o.is_exception     = is_exception_i;
        id_o.exception_cause  = exception_cause_i;
        inst_valid            = 1'b1;

        case (opcode)
            `ADDIW_OPCODE: begin
                id_o.aluop  = `ALU_ADD;
                id_o.alusel = `ALU_SEL_ARITH;
            end
            `LDW_OPCODE: begin
                id_o.aluop  = `ALU_LDW;
                id_o.alusel = `ALU_SEL_LOAD_STORE;
            end
            `STW_OPCODE: begin
                id_o.aluop  = `ALU_STW;
                id_o.alusel = `ALU_SEL_LOAD_STORE;
            end
            default: begin
                inst_valid = 1'b0;
            end
        endcase

        if (inst_valid) begin
            id_o.reg_read_en[0] = 1'b1;
            id_o.imm            = {{20{si12[11]}}, si12};
            // store data comes from rd and nothing is written back.
            if (opcode == `STW_OPCODE) begin
                id_o.reg_read_en[1]   = 1'b1;
                id_o.reg_read_addr[1] = rd;
            end else begin
                id_o.reg_write_en   = 1'b1;
                id_o.reg_write_addr = rd;
            end
        end

        id_o.inst_valid                    = inst_valid;
        id_o.is_exception[`EXC_SLOT_ID]    = ~inst_valid;
        id_o.exception_cause[`EXC_SLOT_ID] = `EXCEPTION_INE;
    end

endmodule

// ==== design/decoder/decoder_2ri14.sv ====
`include "core_macros.svh"

module decoder_2ri14
    import pipeline_pkg::*;
(
    input  bus32_t                            pc_i,
    input  inst_word_t                        inst_i,
    input  logic [`EXC_SLOTS-1:0]             is_exception_i,
    input  exception_cause_t [`EXC_SLOTS-1:0] exception_cause_i,
    output id_dispatch_t                      id_o
);

    logic [7:0]  opcode;
    logic [13:0] si14;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic        inst_valid;

    assign opcode = inst_i.ri14.opcode;
    assign si14   = inst_i.ri14.si14;
    assign rj     = inst_i.ri14.rj;
    assign rd     = inst_i.ri14.rd;

    always_comb begin
        id_o                  = '0;
        id_o.pc               = pc_i;
        id_o.aluop            = `ALU_NOP;
        id_o.alusel           = `ALU_SEL_NOP;
        id_o.reg_read_addr[0] = rj;
        id_o.csr_addr         = si14;
        id_o.is_exception     = is_exception_i;
        id_o.exception_cause  = exception_cause_i;
        inst_valid            = 1'b0;

        case (opcode)
            `LLW_OPCODE: begin
                id_o.aluop          = `ALU_LLW;
                id_o.alusel         = `ALU_SEL_LOAD_STORE;
                id_o.reg_read_en[0] = 1'b1;
                id_o.reg_write_en   = 1'b1;
                id_o.reg_write_addr = rd;
                id_o.csr_read_en    = 1'b1;
                id_o.csr_addr       = `CSR_LLBCTL;
                // word offset.
                id_o.imm            = {{16{si14[13]}}, si14, 2'b00};
                inst_valid          = 1'b1;
            end
            `SCW_OPCODE: begin
                id_o.aluop            = `ALU_SCW;
                id_o.alusel           = `ALU_SEL_LOAD_STORE;
                id_o.reg_read_en      = 2'b11;
                id_o.reg_read_addr[1] = rd;
                id_o.reg_write_en     = 1'b1;
                id_o.reg_write_addr   = rd;
                id_o.csr_read_en      = 1'b1;
                id_o.csr_addr         = `CSR_LLBCTL;
                inst_valid            = 1'b1;
            end
            `CSR_OPCODE: begin
                id_o.is_privilege   = 1'b1;
                id_o.alusel         = `ALU_SEL_CSR;
                id_o.reg_write_en   = 1'b1;
                id_o.reg_write_addr = rd;
                id_o.csr_read_en    = 1'b1;
                inst_valid          = 1'b1;
                case (rj)
                    `CSRRD_OPCODE: begin
                        id_o.aluop = `ALU_CSRRD;
                    end
                    `CSRWR_OPCODE: begin
                        id_o.aluop            = `ALU_CSRWR;
                        id_o.reg_read_en[0]   = 1'b1;
                        id_o.reg_read_addr[0] = rd;
                        id_o.csr_write_en     = 1'b1;
                    end
                    default: begin
                        // for csrxchg rj holds the write mask.
                        id_o.aluop            = `ALU_CSRXCHG;
                        id_o.reg_read_en      = 2'b11;
                        id_o.reg_read_addr[0] = rd;
                        id_o.reg_read_addr[1] = rj;
                        id_o.csr_write_en     = 1'b1;
                    end
                endcase
            end
            default: begin
            end
        endcase

        id_o.inst_valid                         = inst_valid;
        id_o.is_exception[`EXC_SLOT_ID]         = ~inst_valid;
        id_o.exception_cause[`EXC_SLOT_ID]      = `EXCEPTION_INE;
    end

endmodule

// ==== common/pipeline_pkg.sv ====
`include "core_macros.svh"

package pipeline_pkg;

    typedef logic [31:0] bus32_t;

    typedef logic [`EXC_CAUSE_WIDTH-1:0] exception_cause_t;

    // si14 doubles as the csr number for csr access.
    typedef struct packed {
        logic [7:0]  opcode;
        logic [13:0] si14;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri14_fmt_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_fmt_t;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r3_fmt_t;

    // one instruction word seen through each format.
    typedef union packed {
        ri14_fmt_t ri14;
        ri12_fmt_t ri12;
        r3_fmt_t   r3;
    } inst_word_t;

    typedef struct packed {
        bus32_t                                pc;
        logic                                  inst_valid;
        logic [7:0]                            aluop;
        logic [2:0]                            alusel;
        logic [1:0]                            reg_read_en;
        logic [1:0][4:0]                       reg_read_addr;
        logic                                  reg_write_en;
        logic [4:0]                            reg_write_addr;
        bus32_t                                imm;
        logic                                  csr_read_en;
        logic                                  csr_write_en;
        logic [13:0]                           csr_addr;
        logic                                  is_privilege;
        logic [`EXC_SLOTS-1:0]                 is_exception;
        exception_cause_t [`EXC_SLOTS-1:0]     exception_cause;
    } id_dispatch_t;

endpackage

// ==== common/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// exception vector layout.
`define EXC_CAUSE_WIDTH 6
`define EXC_SLOTS 6
`define EXC_SLOT_ID 3

// 2RI14 opcodes in bits 31:24.
`define LLW_OPCODE 8'b0010_0000
`define SCW_OPCODE 8'b0010_0001
`define CSR_OPCODE 8'b0000_0100

// csr sub-opcodes carried in the rj field.
`define CSRRD_OPCODE 5'b00000
`define CSRWR_OPCODE 5'b00001

// 2RI12 opcodes in bits 31:22.
`define ADDIW_OPCODE 10'b00_0000_1010
`define LDW_OPCODE 10'b00_1010_0010
`define STW_OPCODE 10'b00_1010_0110

// 3R opcodes in bits 31:15.
`define ADDW_OPCODE 17'b0_0000_0000_0010_0000
`define SUBW_OPCODE 17'b0_0000_0000_0010_0010
`define AND_OPCODE 17'b0_0000_0000_0010_1001
`define OR_OPCODE 17'b0_0000_0000_0010_1010

// alu operations.
`define ALU_NOP 8'h00
`define ALU_ADD 8'h01
`define ALU_SUB 8'h02
`define ALU_AND 8'h03
`define ALU_OR 8'h04
`define ALU_LDW 8'h10
`define ALU_STW 8'h11
`define ALU_LLW 8'h12
`define ALU_SCW 8'h13
`define ALU_CSRRD 8'h20
`define ALU_CSRWR 8'h21
`define ALU_CSRXCHG 8'h22

// execution unit selects.
`define ALU_SEL_NOP 3'b000
`define ALU_SEL_ARITH 3'b001
`define ALU_SEL_LOGIC 3'b010
`define ALU_SEL_LOAD_STORE 3'b011
`define ALU_SEL_CSR 3'b100

`define CSR_LLBCTL 14'h060

// instruction not exist.
`define EXCEPTION_INE 6'h0d

`endif
